// ==== Makefile ====
# Verilator build and run of the dual-issue core testbench

VERILATOR ?= verilator
TOP       ?= tb_dual_issue_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the run prints the pass message
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src/alu_lane.sv ====
/*
 * One lane from execute to writeback, two register stages.
 * ex_data is the ALU output of the current execute cycle.
 */
`default_nettype none

module alu_lane
	import rv_pkg::*;
(
	input  wire logic            clk,
	input  wire logic            i_rst_n,
	lane_decode_if.ex            dec,
	input  wire logic [XLEN-1:0] i_op_a,
	input  wire logic [XLEN-1:0] i_op_b,
	lane_result_if.prod          res
);

	localparam int SHAMT_W = $clog2(XLEN);

	logic                  ex_valid;
	logic [ALU_OP_W-1:0]   ex_op;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_rd_en;
	logic                  ex_use_imm;
	logic [XLEN-1:0]       ex_a;
	logic [XLEN-1:0]       ex_b;
	logic [XLEN-1:0]       ex_imm;
	logic [XLEN-1:0]       src_b;
	logic [XLEN-1:0]       alu_out;
	logic                  ex_en;

	// Execute stage
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ex_valid   <= 1'b0;
			ex_op      <= ALU_ADD;
			ex_rd      <= '0;
			ex_rd_en   <= 1'b0;
			ex_use_imm <= 1'b0;
			ex_a       <= '0;
			ex_b       <= '0;
			ex_imm     <= '0;
		end else begin
			ex_valid   <= dec.valid;
			ex_op      <= dec.alu_op;
			ex_rd      <= dec.rd;
			ex_rd_en   <= dec.rd_en;
			ex_use_imm <= dec.use_imm;
			ex_a       <= i_op_a;
			ex_b       <= i_op_b;
			ex_imm     <= dec.imm;
		end
	end

	assign src_b = ex_use_imm ? ex_imm : ex_b;

	always_comb begin
		case (ex_op)
			ALU_SUB: alu_out = ex_a - src_b;
			ALU_AND: alu_out = ex_a & src_b;
			ALU_OR:  alu_out = ex_a | src_b;
			ALU_XOR: alu_out = ex_a ^ src_b;
			ALU_SLL: alu_out = ex_a << src_b[SHAMT_W-1:0];
			ALU_SRL: alu_out = ex_a >> src_b[SHAMT_W-1:0];
			ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(ex_a) < $signed(src_b)};
			default: alu_out = ex_a + src_b;
		endcase
	end

	assign ex_en       = ex_valid & ex_rd_en;
	assign res.ex_en   = ex_en;
	assign res.ex_rd   = ex_rd;
	assign res.ex_data = alu_out;

	// Writeback stage
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			res.wb_en   <= 1'b0;
			res.wb_rd   <= '0;
			res.wb_data <= '0;
		end else begin
			res.wb_en   <= ex_en;
			res.wb_rd   <= ex_rd;
			res.wb_data <= alu_out;
		end
	end

endmodule

`default_nettype wire

// ==== src/dual_issue_core.sv ====
/*
 * Dual-issue in-order ALU core, fetch/decode, execute and writeback stages.
 * The fetch port must answer in the same cycle, no stalls are supported.
 * Lane 0 is the older of two writes retiring together.
 */
`default_nettype none

module dual_issue_core
	import rv_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
)
(
	input  wire logic                  clk,
	input  wire logic                  i_rst_n,
	output logic      [XLEN-1:0]       o_fetch_pc,
	input  wire logic [FETCH_W-1:0]    i_fetch_instr,
	output logic                       o_wb_en_0,
	output logic                       o_wb_en_1,
	output logic      [REG_ADDR_W-1:0] o_wb_addr_0,
	output logic      [REG_ADDR_W-1:0] o_wb_addr_1,
	output logic      [XLEN-1:0]       o_wb_data_0,
	output logic      [XLEN-1:0]       o_wb_data_1
);

	logic [INSTR_W-1:0] instr_0;
	logic [INSTR_W-1:0] instr_1;
	logic [XLEN-1:0]    rf_data_0a;
	logic [XLEN-1:0]    rf_data_0b;
	logic [XLEN-1:0]    rf_data_1a;
	logic [XLEN-1:0]    rf_data_1b;
	logic [XLEN-1:0]    op_a_0;
	logic [XLEN-1:0]    op_b_0;
	logic [XLEN-1:0]    op_a_1;
	logic [XLEN-1:0]    op_b_1;

	lane_decode_if dec0 ();
	lane_decode_if dec1 ();
	lane_result_if res0 ();
	lane_result_if res1 ();

	pair_issue_ctrl #(
		.RESET_PC (RESET_PC)
	) u_issue (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_fetch_instr (i_fetch_instr),
		.o_fetch_pc    (o_fetch_pc),
		.o_instr_0     (instr_0),
		.o_instr_1     (instr_1),
		.dec0          (dec0.issue),
		.dec1          (dec1.issue)
	);

	lane_decoder u_dec0 (
		.i_instr (instr_0),
		.dec     (dec0.dec)
	);

	lane_decoder u_dec1 (
		.i_instr (instr_1),
		.dec     (dec1.dec)
	);

	reg_file u_rf (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_rs_addr_0a (dec0.rs1),
		.i_rs_addr_0b (dec0.rs2),
		.i_rs_addr_1a (dec1.rs1),
		.i_rs_addr_1b (dec1.rs2),
		.o_rs_data_0a (rf_data_0a),
		.o_rs_data_0b (rf_data_0b),
		.o_rs_data_1a (rf_data_1a),
		.o_rs_data_1b (rf_data_1b),
		.res0         (res0.cons),
		.res1         (res1.cons)
	);

	operand_bypass u_byp (
		.dec0         (dec0.byp),
		.dec1         (dec1.byp),
		.i_rf_data_0a (rf_data_0a),
		.i_rf_data_0b (rf_data_0b),
		.i_rf_data_1a (rf_data_1a),
		.i_rf_data_1b (rf_data_1b),
		.res0         (res0.cons),
		.res1         (res1.cons),
		.o_op_a_0     (op_a_0),
		.o_op_b_0     (op_b_0),
		.o_op_a_1     (op_a_1),
		.o_op_b_1     (op_b_1)
	);

	alu_lane u_lane0 (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.dec     (dec0.ex),
		.i_op_a  (op_a_0),
		.i_op_b  (op_b_0),
		.res     (res0.prod)
	);

	alu_lane u_lane1 (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.dec     (dec1.ex),
		.i_op_a  (op_a_1),
		.i_op_b  (op_b_1),
		.res     (res1.prod)
	);

	assign o_wb_en_0   = res0.wb_en;
	assign o_wb_en_1   = res1.wb_en;
	assign o_wb_addr_0 = res0.wb_rd;
	assign o_wb_addr_1 = res1.wb_rd;
	assign o_wb_data_0 = res0.wb_data;
	assign o_wb_data_1 = res1.wb_data;

endmodule

`default_nettype wire

// ==== src/lane_decode_if.sv ====
/*
 * One decoded lane. Valid comes from issue control, the rest from the decoder.
 */
`default_nettype none

interface lane_decode_if
	import rv_pkg::*;
();
	logic                  valid;
	logic [ALU_OP_W-1:0]   alu_op;
	logic [REG_ADDR_W-1:0] rd;
	logic                  rd_en;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic                  use_imm;
	logic [XLEN-1:0]       imm;

	modport dec (output alu_op, rd, rd_en, rs1, rs2, use_imm, imm);
	// Issue control sees the register fields to detect an in-pair dependency
	modport issue (output valid, input rd, rd_en, rs1, rs2, use_imm);
	modport byp (input rs1, rs2, use_imm);
	modport ex (input valid, alu_op, rd, rd_en, use_imm, imm);

endinterface

`default_nettype wire

// ==== src/lane_decoder.sv ====
/*
 * Decodes one word. Anything outside the kept ALU ops comes out as
 * ADDI x0,x0,0 with rd_en low, so it never splits a pair.
 */
`default_nettype none

module lane_decoder
	import rv_pkg::*;
(
	input  wire logic [INSTR_W-1:0] i_instr,
	lane_decode_if.dec              dec
);

	rv_instr_u           instr;
	logic                supported;
	logic                is_imm;
	logic [ALU_OP_W-1:0] op;

	assign instr = i_instr;

	always_comb begin
		supported = 1'b0;
		is_imm    = 1'b0;
		op        = ALU_ADD;
		case (instr.r.opcode)
			OPC_OP: begin
				supported = 1'b1;
				case (instr.r.funct3)
					F3_ADD: op = (instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLL: op = ALU_SLL;
					F3_SLT: op = ALU_SLT;
					F3_XOR: op = ALU_XOR;
					F3_SRL: op = ALU_SRL;
					F3_OR:  op = ALU_OR;
					F3_AND: op = ALU_AND;
					// SLTU is not kept
					default: supported = 1'b0;
				endcase
				// SUB is the only other funct7 kept, and only with funct3 ADD
				if (instr.r.funct7 != F7_BASE &&
					!(instr.r.funct7 == F7_SUB && instr.r.funct3 == F3_ADD))
					supported = 1'b0;
			end
			OPC_OP_IMM: begin
				is_imm = 1'b1;
				supported = 1'b1;
				case (instr.i.funct3)
					F3_ADD: op = ALU_ADD;
					F3_SLT: op = ALU_SLT;
					F3_XOR: op = ALU_XOR;
					F3_OR:  op = ALU_OR;
					F3_AND: op = ALU_AND;
					// Shift-immediate forms are not kept
					default: supported = 1'b0;
				endcase
			end
			default: supported = 1'b0;
		endcase
	end

	assign dec.alu_op  = supported ? op : ALU_ADD;
	assign dec.rd      = supported ? instr.r.rd : '0;
	assign dec.rd_en   = supported && (instr.r.rd != '0);
	assign dec.rs1     = supported ? instr.r.rs1 : '0;
	assign dec.rs2     = supported ? instr.r.rs2 : '0;
	assign dec.use_imm = supported ? is_imm : 1'b1;
	assign dec.imm     = (supported && is_imm) ?
		{{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12} : '0;

endmodule

`default_nettype wire

// ==== src/lane_result_if.sv ====
/*
 * Execute and writeback results of one lane. An en is set only for a valid
 * instruction that writes a nonzero rd.
 */
`default_nettype none

interface lane_result_if
	import rv_pkg::*;
();
	logic                  ex_en;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic [XLEN-1:0]       ex_data;
	logic                  wb_en;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0]       wb_data;

	modport prod (output ex_en, ex_rd, ex_data, wb_en, wb_rd, wb_data);
	modport cons (input ex_en, ex_rd, ex_data, wb_en, wb_rd, wb_data);

endinterface

`default_nettype wire

// ==== src/operand_bypass.sv ====
/*
 * Operand selection for both lanes. Priority follows age, youngest first.
 * There is no in-pair forwarding because a dependent pair is split before it gets here.
 */
`default_nettype none

module operand_bypass
	import rv_pkg::*;
(
	lane_decode_if.byp           dec0,
	lane_decode_if.byp           dec1,
	input  wire logic [XLEN-1:0] i_rf_data_0a,
	input  wire logic [XLEN-1:0] i_rf_data_0b,
	input  wire logic [XLEN-1:0] i_rf_data_1a,
	input  wire logic [XLEN-1:0] i_rf_data_1b,
	lane_result_if.cons          res0,
	lane_result_if.cons          res1,
	output logic      [XLEN-1:0] o_op_a_0,
	output logic      [XLEN-1:0] o_op_b_0,
	output logic      [XLEN-1:0] o_op_a_1,
	output logic      [XLEN-1:0] o_op_b_1
);

	function automatic logic [XLEN-1:0] select_operand(
		input logic [REG_ADDR_W-1:0] rs,
		input logic [XLEN-1:0]       rf_data
	);
		logic [XLEN-1:0] val;
		if (rs == '0)
			val = '0;
		else if (res1.ex_en && (res1.ex_rd == rs))
			val = res1.ex_data;
		else if (res0.ex_en && (res0.ex_rd == rs))
			val = res0.ex_data;
		else if (res1.wb_en && (res1.wb_rd == rs))
			val = res1.wb_data;
		else if (res0.wb_en && (res0.wb_rd == rs))
			val = res0.wb_data;
		else
			val = rf_data;
		return val;
	endfunction

	always_comb begin
		o_op_a_0 = select_operand(dec0.rs1, i_rf_data_0a);
		o_op_a_1 = select_operand(dec1.rs1, i_rf_data_1a);
		// Immediate lanes take their second operand in the ALU stage
		o_op_b_0 = dec0.use_imm ? '0 : select_operand(dec0.rs2, i_rf_data_0b);
		o_op_b_1 = dec1.use_imm ? '0 : select_operand(dec1.rs2, i_rf_data_1b);
	end

endmodule

`default_nettype wire

// ==== src/pair_issue_ctrl.sv ====
/*
 * Fetch PC and pair register. Fetch returns the pair in the same cycle.
 * A split pair refetches its second word, so the PC may be 4-aligned only.
 */
`default_nettype none

module pair_issue_ctrl
	import rv_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
)
(
	input  wire logic               clk,
	input  wire logic               i_rst_n,
	input  wire logic [FETCH_W-1:0] i_fetch_instr,
	output logic      [XLEN-1:0]    o_fetch_pc,
	output logic      [INSTR_W-1:0] o_instr_0,
	output logic      [INSTR_W-1:0] o_instr_1,
	lane_decode_if.issue            dec0,
	lane_decode_if.issue            dec1
);

	localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(INSTR_W / 8);

	logic [XLEN-1:0]    pair_pc;
	logic               pair_valid;
	logic [INSTR_W-1:0] instr_0_q;
	logic [INSTR_W-1:0] instr_1_q;
	logic               split;

	// Lane 1 depends on lane 0, rs2 only counts for the R-type form
	assign split = dec0.rd_en &&
		((dec1.rs1 == dec0.rd) || (!dec1.use_imm && (dec1.rs2 == dec0.rd)));

	assign dec0.valid = pair_valid;
	assign dec1.valid = pair_valid & ~split;

	always_comb begin
		if (!pair_valid)
			o_fetch_pc = RESET_PC;
		else if (split)
			o_fetch_pc = pair_pc + INSTR_BYTES;
		else
			o_fetch_pc = pair_pc + (INSTR_BYTES << 1);
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pair_valid <= 1'b0;
			pair_pc    <= RESET_PC;
			instr_0_q  <= NOP_INSTR;
			instr_1_q  <= NOP_INSTR;
		end else begin
			pair_valid <= 1'b1;
			pair_pc    <= o_fetch_pc;
			instr_0_q  <= i_fetch_instr[INSTR_W-1:0];
			instr_1_q  <= i_fetch_instr[FETCH_W-1:INSTR_W];
		end
	end

	assign o_instr_0 = instr_0_q;
	assign o_instr_1 = instr_1_q;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
/*
 * 31 integer registers, x0 hard-wired to zero. Reads are combinational and
 * see no same-cycle write, the bypass network covers that case.
 */
`default_nettype none

module reg_file
	import rv_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  i_rst_n,
	input  wire logic [REG_ADDR_W-1:0] i_rs_addr_0a,
	input  wire logic [REG_ADDR_W-1:0] i_rs_addr_0b,
	input  wire logic [REG_ADDR_W-1:0] i_rs_addr_1a,
	input  wire logic [REG_ADDR_W-1:0] i_rs_addr_1b,
	output logic      [XLEN-1:0]       o_rs_data_0a,
	output logic      [XLEN-1:0]       o_rs_data_0b,
	output logic      [XLEN-1:0]       o_rs_data_1a,
	output logic      [XLEN-1:0]       o_rs_data_1b,
	lane_result_if.cons                res0,
	lane_result_if.cons                res1
);

	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int k = 1; k < 32; k++)
				regs[k] <= '0;
		end else begin
			if (res0.wb_en)
				regs[res0.wb_rd] <= res0.wb_data;
			// Lane 1 is younger and overrides lane 0 on the same rd
			if (res1.wb_en)
				regs[res1.wb_rd] <= res1.wb_data;
		end
	end

	assign o_rs_data_0a = (i_rs_addr_0a == '0) ? '0 : regs[i_rs_addr_0a];
	assign o_rs_data_0b = (i_rs_addr_0b == '0) ? '0 : regs[i_rs_addr_0b];
	assign o_rs_data_1a = (i_rs_addr_1a == '0) ? '0 : regs[i_rs_addr_1a];
	assign o_rs_data_1b = (i_rs_addr_1b == '0) ? '0 : regs[i_rs_addr_1b];

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
/*
 * Shared widths and encodings of the dual-issue integer core.
 * Only the RV32I register-register and register-immediate ALU ops are encoded.
 */
`default_nettype none

package rv_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int INSTR_W    = 32;
	localparam int FETCH_W    = 2 * INSTR_W;
	localparam int ALU_OP_W   = 4;

	// ALU operation codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd7;

	// Major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3, shared by R-type and I-type forms
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// ADDI x0, x0, 0
	localparam logic [INSTR_W-1:0] NOP_INSTR = 32'h0000_0013;

	typedef union packed {
		struct packed {
			logic [6:0]            funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} r;
		struct packed {
			logic [11:0]           imm12;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} i;
	} rv_instr_u;

endpackage

`default_nettype wire

// ==== tb.f ====
src/rv_pkg.sv
src/lane_decode_if.sv
src/lane_result_if.sv
src/pair_issue_ctrl.sv
src/lane_decoder.sv
src/reg_file.sv
src/operand_bypass.sv
src/alu_lane.sv
src/dual_issue_core.sv
test/tb_dual_issue_core.sv

// ==== test/tb_dual_issue_core.sv ====
/*
 * Testbench for the dual-issue core. Runs a straight-line program from a ROM
 * at RESET_PC and checks every write against an in-order reference model.
 * Words past the end of the ROM read as NOP_INSTR.
 */
`default_nettype none

module tb_dual_issue_core
	import rv_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int PROG_LEN     = 96;
	localparam int DIRECTED_LEN = 16;
	localparam int MAX_CYCLES   = 400;
	localparam int DRAIN_CYCLES = 20;
	localparam logic [31:0] SEED = 32'h5a5193cf;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic [XLEN-1:0]       fetch_pc;
	logic [FETCH_W-1:0]    fetch_instr;
	logic                  wb_en_0;
	logic                  wb_en_1;
	logic [REG_ADDR_W-1:0] wb_addr_0;
	logic [REG_ADDR_W-1:0] wb_addr_1;
	logic [XLEN-1:0]       wb_data_0;
	logic [XLEN-1:0]       wb_data_1;

	logic [INSTR_W-1:0]         rom [PROG_LEN];
	logic [XLEN-1:0]            model_regs [32];
	logic [REG_ADDR_W+XLEN-1:0] exp_q [$];
	logic [XLEN-1:0]            prev_pc;

	// Counters of the checking process
	int write_cnt = 0;
	int write_err_cnt = 0;
	int extra_err_cnt = 0;
	int dual_cnt = 0;
	int edges_after_reset = 0;
	// Counters of the stimulus process
	int pc_err_cnt = 0;
	int run_err_cnt = 0;
	int split_cnt = 0;

	dual_issue_core #(
		.RESET_PC (RESET_PC)
	) dut0 (
		.clk           (clk),
		.i_rst_n       (rst_n),
		.o_fetch_pc    (fetch_pc),
		.i_fetch_instr (fetch_instr),
		.o_wb_en_0     (wb_en_0),
		.o_wb_en_1     (wb_en_1),
		.o_wb_addr_0   (wb_addr_0),
		.o_wb_addr_1   (wb_addr_1),
		.o_wb_data_0   (wb_data_0),
		.o_wb_data_1   (wb_data_1)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [INSTR_W-1:0] encode_r(input logic [6:0] f7,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
		input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [INSTR_W-1:0] encode_i(input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [INSTR_W-1:0] random_kept();
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [11:0]           imm;
		logic [INSTR_W-1:0]    w;
		// Registers x0 to x7 only so that short-distance dependencies are frequent
		rd  = REG_ADDR_W'($urandom % 8);
		rs1 = REG_ADDR_W'($urandom % 8);
		rs2 = REG_ADDR_W'($urandom % 8);
		imm = 12'($urandom);
		case ($urandom % 13)
			0: w = encode_r(F7_BASE, rs2, rs1, F3_ADD, rd);
			1: w = encode_r(F7_SUB, rs2, rs1, F3_ADD, rd);
			2: w = encode_r(F7_BASE, rs2, rs1, F3_AND, rd);
			3: w = encode_r(F7_BASE, rs2, rs1, F3_OR, rd);
			4: w = encode_r(F7_BASE, rs2, rs1, F3_XOR, rd);
			5: w = encode_r(F7_BASE, rs2, rs1, F3_SLL, rd);
			6: w = encode_r(F7_BASE, rs2, rs1, F3_SRL, rd);
			7: w = encode_r(F7_BASE, rs2, rs1, F3_SLT, rd);
			8: w = encode_i(imm, rs1, F3_ADD, rd);
			9: w = encode_i(imm, rs1, F3_AND, rd);
			10: w = encode_i(imm, rs1, F3_OR, rd);
			11: w = encode_i(imm, rs1, F3_XOR, rd);
			default: w = encode_i(imm, rs1, F3_SLT, rd);
		endcase
		return w;
	endfunction

	function automatic logic [INSTR_W-1:0] invalid_word();
		logic [INSTR_W-1:0] w;
		case ($urandom % 6)
			0: w = 32'h0000_2083;
			1: w = encode_i(12'h002, 5'd1, F3_SLL, 5'd3);
			2: w = encode_r(7'b0000001, 5'd7, 5'd6, F3_ADD, 5'd5);
			3: w = 32'h1234_50b7;
			// SLTU
			4: w = encode_r(F7_BASE, 5'd2, 5'd1, 3'b011, 5'd4);
			default: w = 32'hffff_ffff;
		endcase
		return w;
	endfunction

	function automatic logic kept_word(input logic [INSTR_W-1:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = w[14:12];
		f7 = w[31:25];
		// SLTU is not a kept op
		if (w[6:0] == OPC_OP)
			return (f7 == F7_BASE && f3 != 3'b011) || (f7 == F7_SUB && f3 == F3_ADD);
		if (w[6:0] == OPC_OP_IMM)
			return f3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND};
		return 1'b0;
	endfunction

	// Reference model of one instruction returning {write, rd, value}
	function automatic logic [REG_ADDR_W+XLEN:0] ref_exec(input logic [INSTR_W-1:0] w);
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       a;
		logic [XLEN-1:0]       b;
		logic [XLEN-1:0]       val;
		rd = w[11:7];
		if (!kept_word(w) || rd == '0)
			return '0;
		a = model_regs[w[19:15]];
		if (w[6:0] == OPC_OP)
			b = model_regs[w[24:20]];
		else
			b = {{(XLEN-12){w[31]}}, w[31:20]};
		case (w[14:12])
			F3_ADD: val = (w[6:0] == OPC_OP && w[31:25] == F7_SUB) ? a - b : a + b;
			F3_SLL: val = a << b[4:0];
			F3_SRL: val = a >> b[4:0];
			F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_XOR: val = a ^ b;
			F3_OR:  val = a | b;
			default: val = a & b;
		endcase
		return {1'b1, rd, val};
	endfunction

	function automatic logic [INSTR_W-1:0] rom_word(input logic [XLEN-1:0] addr);
		logic [XLEN-1:0] offset;
		offset = addr - RESET_PC;
		if (offset[1:0] == 2'b00 && (offset >> 2) < XLEN'(PROG_LEN))
			return rom[offset >> 2];
		return NOP_INSTR;
	endfunction

	function automatic logic [FETCH_W-1:0] fetch_pair(input logic [XLEN-1:0] pc);
		return {rom_word(pc + 32'd4), rom_word(pc)};
	endfunction

	// Lane 1 depends on lane 0 through rs1, or rs2 of an R-type word
	function automatic logic [XLEN-1:0] pc_step(input logic [XLEN-1:0] pc);
		logic [INSTR_W-1:0] w0;
		logic [INSTR_W-1:0] w1;
		logic               dep;
		w0 = rom_word(pc);
		w1 = rom_word(pc + 32'd4);
		dep = kept_word(w0) && (w0[11:7] != '0) && kept_word(w1) &&
			((w1[19:15] == w0[11:7]) || (w1[6:0] == OPC_OP && w1[24:20] == w0[11:7]));
		return dep ? 32'd4 : 32'd8;
	endfunction

	task automatic load_program();
		// Directed head with rs1 and rs2 splits, x0 write and read, an SLTU word
		// that is not kept, an immediate whose rs2 field equals the older rd
		rom[0]  = encode_i(12'd100, 5'd0, F3_ADD, 5'd1);
		rom[1]  = encode_i(12'hff9, 5'd0, F3_ADD, 5'd2);
		rom[2]  = encode_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3);
		rom[3]  = encode_r(F7_SUB, 5'd1, 5'd3, F3_ADD, 5'd4);
		rom[4]  = encode_i(12'h5a5, 5'd3, F3_XOR, 5'd5);
		rom[5]  = encode_r(F7_BASE, 5'd5, 5'd4, F3_SLT, 5'd6);
		rom[6]  = encode_r(F7_BASE, 5'd4, 5'd6, F3_OR, 5'd7);
		rom[7]  = encode_r(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd0);
		rom[8]  = encode_r(F7_BASE, 5'd7, 5'd0, F3_ADD, 5'd8);
		rom[9]  = encode_i(12'h0f0, 5'd8, F3_AND, 5'd9);
		rom[10] = encode_r(F7_BASE, 5'd2, 5'd1, 3'b011, 5'd15);
		rom[11] = encode_i(12'h001, 5'd0, F3_OR, 5'd13);
		rom[12] = encode_i(12'h00d, 5'd1, F3_ADD, 5'd14);
		rom[13] = encode_r(F7_BASE, 5'd1, 5'd2, F3_ADD, 5'd11);
		rom[14] = encode_r(F7_SUB, 5'd11, 5'd1, F3_ADD, 5'd12);
		rom[15] = encode_r(F7_BASE, 5'd3, 5'd9, F3_SRL, 5'd10);
		for (int k = DIRECTED_LEN; k < PROG_LEN; k++) begin
			if ($urandom % 8 == 0)
				rom[k] = invalid_word();
			else
				rom[k] = random_kept();
		end
	endtask

	task automatic build_expected();
		logic [REG_ADDR_W+XLEN:0] res;
		for (int k = 0; k < 32; k++)
			model_regs[k] = '0;
		for (int k = 0; k < PROG_LEN; k++) begin
			res = ref_exec(rom[k]);
			if (res[REG_ADDR_W+XLEN]) begin
				exp_q.push_back(res[REG_ADDR_W+XLEN-1:0]);
				model_regs[res[XLEN +: REG_ADDR_W]] = res[XLEN-1:0];
			end
		end
	endtask

	// Checks the new fetch PC on a falling edge, then answers the fetch
	task automatic drive_cycle(input logic check_pc);
		logic [XLEN-1:0] step;
		@(negedge clk);
		step = pc_step(prev_pc);
		if (check_pc) begin
			if (fetch_pc !== prev_pc + step) begin
				pc_err_cnt++;
				$display("CHECK FAILED fetch pc: expected %h, actual %h",
					prev_pc + step, fetch_pc);
			end
			if (fetch_pc === prev_pc + 32'd4)
				split_cnt++;
		end
		fetch_instr = fetch_pair(fetch_pc);
		prev_pc = fetch_pc;
	endtask

	task automatic check_write(input string lane, input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0] data);
		logic [REG_ADDR_W+XLEN-1:0] expected;
		write_cnt++;
		if (exp_q.size() == 0) begin
			extra_err_cnt++;
			$display("ERROR: %s wrote x%0d = %h after the last expected write",
				lane, addr, data);
			return;
		end
		expected = exp_q.pop_front();
		if (addr !== expected[XLEN +: REG_ADDR_W]) begin
			write_err_cnt++;
			$display("CHECK FAILED %s address: expected x%0d, actual x%0d",
				lane, expected[XLEN +: REG_ADDR_W], addr);
		end
		if (data !== expected[XLEN-1:0]) begin
			write_err_cnt++;
			$display("CHECK FAILED %s data: expected %h, actual %h",
				lane, expected[XLEN-1:0], data);
		end
	endtask

	// Lane 0 is older, so its write is matched first
	always @(posedge clk) begin
		if (!rst_n)
			edges_after_reset = 0;
		else
			edges_after_reset++;
		if (edges_after_reset <= 3 && (wb_en_0 || wb_en_1)) begin
			extra_err_cnt++;
			$display("ERROR: write enable high %0d edges after reset release",
				edges_after_reset);
		end
		if (wb_en_0 && wb_en_1)
			dual_cnt++;
		if (wb_en_0)
			check_write("lane 0", wb_addr_0, wb_data_0);
		if (wb_en_1)
			check_write("lane 1", wb_addr_1, wb_data_1);
	end

	initial begin
		int cycles;
		void'($urandom(SEED));
		rst_n       = 1'b0;
		fetch_instr = {NOP_INSTR, NOP_INSTR};
		prev_pc     = RESET_PC;
		load_program();
		build_expected();
		repeat (RESET_CYCLES - 1)
			drive_cycle(1'b0);
		@(negedge clk);
		rst_n = 1'b1;
		if (fetch_pc !== RESET_PC) begin
			pc_err_cnt++;
			$display("CHECK FAILED pc after reset: expected %h, actual %h",
				RESET_PC, fetch_pc);
		end
		fetch_instr = fetch_pair(fetch_pc);
		prev_pc = fetch_pc;

		cycles = 0;
		while (exp_q.size() != 0 && cycles < MAX_CYCLES) begin
			drive_cycle(1'b1);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			run_err_cnt++;
			$display("ERROR: timed out with %0d expected writes still pending",
				exp_q.size());
		end else begin
			// Nothing may retire once the program is done
			for (int k = 0; k < DRAIN_CYCLES; k++)
				drive_cycle(1'b1);
		end
		if (split_cnt == 0 || dual_cnt == 0) begin
			run_err_cnt++;
			$display("ERROR: no split pair or no dual retirement was seen");
		end

		$display("writes %0d, write errors %0d, pc errors %0d, other errors %0d",
			write_cnt, write_err_cnt, pc_err_cnt, extra_err_cnt + run_err_cnt);
		if (write_err_cnt + pc_err_cnt + extra_err_cnt + run_err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
